//--- jtag_dbg.f
+incdir+logic
logic/jtag_pkg.sv
logic/dbg_pkg.sv
logic/jtag_dr_if.sv
logic/jtag_tck_sync.sv
logic/jtag_tap_fsm.sv
logic/jtag_shift_reg.sv
logic/jtag_tap.sv
logic/jtag_dbg_dr.sv
logic/jtag_dbg_top.sv
bench/tb_jtag_dbg.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the JTAG debug port and its testbench with Verilator, then run it.
# The run counts as passed only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_jtag_dbg -f jtag_dbg.f -o tb_jtag_dbg \
    && ./obj_dir/tb_jtag_dbg | tee "$LOG" \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -qx "Test OK" "$LOG" \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see $LOG"; exit 1; }

//--- bench/jtag_dbg_vectors.txt
# op bits tdi_hex expected_tdo_hex, values LSB first, one scan per line
# RESET gives TMS-high clocks in bits, CTRL compares ctrl_o with the last column
DR 32 000000000 01db00a3f
IR 5 1f 05
DR 8 a5 4a
IR 5 07 05
DR 16 1234 2468
IR 5 00 05
DR 4 f e
IR 5 10 05
DR 36 8deadbeef 000000000
CTRL 32 0 deadbeef
DR 36 9cafef00d 000000000
DR 36 500000000 000000000
DR 36 000000000 0cafef00d
DR 36 b12345678 0cafef00d
DR 36 700000000 0cafef00d
DR 36 400000000 012345678
DR 36 000000000 0deadbeef
CTRL 32 0 deadbeef
DR 36 100000000 0deadbeef
DR 36 000000000 1deadbeef
IR 5 1f 05
DR 8 3c 78
RESET 5 0 0
DR 32 000000000 01db00a3f
IR 5 10 05
DR 36 000000000 1deadbeef
CTRL 32 0 deadbeef

//--- bench/tb_jtag_dbg.sv
// --------------------
// Testbench for the JTAG debug access port
// Vector file reader, TCK/TMS/TDI bit-bang tasks
// TDO, tdo_oe_o and ctrl_o checks with per-vector report
// --------------------

`include "jtag_defs.svh"

module tb_jtag_dbg;

    timeunit 1ns;
    timeprecision 1ps;

    // clk cycles per TCK half period
    localparam int HALF_TCK = 4;
    // Operation codes of the vector file
    localparam int VEC_RESET = 0;
    localparam int VEC_IR    = 1;
    localparam int VEC_DR    = 2;
    localparam int VEC_CTRL  = 3;

    logic                   clk    = 1'b0;
    logic                   rst_n  = 1'b0;
    logic                   tck    = 1'b0;
    logic                   tms    = 1'b0;
    logic                   tdi    = 1'b0;
    logic                   tdo;
    logic                   tdo_oe;
    logic [`DBG_DATA_W-1:0] ctrl;

    // Vector table
    int          vec_op   [$];
    int          vec_bits [$];
    logic [63:0] vec_din  [$];
    logic [63:0] vec_dout [$];

    logic load_ok     = 1'b1;
    int   err_cnt     = 0;
    int   vec_pass    = 0;
    int   vec_fail    = 0;
    int   cycle_cnt   = 0;
    int   cycle_limit = 0;

    jtag_dbg_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .tck_i    (tck),
        .tms_i    (tms),
        .tdi_i    (tdi),
        .tdo_o    (tdo),
        .tdo_oe_o (tdo_oe),
        .ctrl_o   (ctrl)
    );

    // 40 ns system clock
    always #20 clk = ~clk;

    // Run limit from the total scan length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run went past %0d clk cycles and was stopped", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic int op_code(input logic [63:0] tok);
        if (tok == 64'("RESET")) return VEC_RESET;
        if (tok == 64'("IR")) return VEC_IR;
        if (tok == 64'("DR")) return VEC_DR;
        if (tok == 64'("CTRL")) return VEC_CTRL;
        return -1;
    endfunction

    function automatic string op_name(input int code);
        case (code)
            VEC_RESET: return "RESET";
            VEC_IR:    return "IR";
            VEC_DR:    return "DR";
            default:   return "CTRL";
        endcase
    endfunction

    // --------------------
    // Vector file
    // --------------------
    task automatic load_vectors();
        int               fd;
        int               rc;
        int               code;
        int               nbits;
        logic [63:0]      tok;
        logic [63:0]      din;
        logic [63:0]      dout;
        logic [8*160-1:0] rest;
        fd = $fopen("bench/jtag_dbg_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file bench/jtag_dbg_vectors.txt");
            load_ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            rc = $fscanf(fd, "%s", tok);
            if (rc != 1) begin
                break;
            end
            if (tok == 64'("#")) begin
                // Skip the rest of a comment line
                rc = $fgets(rest, fd);
            end else begin
                rc   = $fscanf(fd, "%d %h %h", nbits, din, dout);
                code = op_code(tok);
                if (rc != 3 || code < 0) begin
                    $display("Vector file holds a line that cannot be parsed");
                    load_ok = 1'b0;
                end else begin
                    vec_op.push_back(code);
                    vec_bits.push_back(nbits);
                    vec_din.push_back(din);
                    vec_dout.push_back(dout);
                end
            end
        end
        $fclose(fd);
    endtask

    // --------------------
    // JTAG bit-bang
    // --------------------
    // One TCK period, low half first, TDO read just before the rise
    task automatic clock_tck(input logic tms_v, input logic tdi_v, output logic tdo_v);
        @(posedge clk);
        tck <= 1'b0;
        tms <= tms_v;
        tdi <= tdi_v;
        repeat (HALF_TCK - 1) @(posedge clk);
        @(negedge clk);
        tdo_v = tdo;
        @(posedge clk);
        tck <= 1'b1;
        repeat (HALF_TCK - 1) @(posedge clk);
    endtask

    // Full IR or DR scan from RunTestIdle back to RunTestIdle
    task automatic scan(input logic is_ir, input int nbits, input logic [63:0] din,
                        output logic [63:0] dout);
        logic [63:0] shift_in;
        logic        bit_out;
        shift_in = din;
        dout     = '0;
        clock_tck(1'b1, 1'b0, bit_out);
        // Extra step through SelectDR for the IR column
        if (is_ir) begin
            clock_tck(1'b1, 1'b0, bit_out);
        end
        clock_tck(1'b0, 1'b0, bit_out);
        // Capture happens on this rise
        clock_tck(1'b0, 1'b0, bit_out);
        for (int b = 0; b < nbits; b++) begin
            // TMS high on the last bit leaves for Exit1
            clock_tck(b == nbits - 1, shift_in[0], bit_out);
            dout     = dout | (64'(bit_out) << b);
            shift_in = shift_in >> 1;
        end
        // Exit1 to Update, then Update to RunTestIdle
        clock_tck(1'b1, 1'b0, bit_out);
        clock_tck(1'b0, 1'b0, bit_out);
        // Idle period so the register write lands before the next check
        clock_tck(1'b0, 1'b0, bit_out);
    endtask

    // TMS held high, then one low clock into RunTestIdle
    task automatic tms_reset(input int nclk);
        logic bit_out;
        for (int k = 0; k < nclk; k++) begin
            clock_tck(1'b1, 1'b0, bit_out);
        end
        clock_tck(1'b0, 1'b0, bit_out);
    endtask

    // --------------------
    // One vector
    // --------------------
    task automatic run_vector(input int idx);
        logic [63:0] got;
        int          errs_at_start;
        errs_at_start = err_cnt;
        got           = '0;
        case (vec_op[idx])
            VEC_RESET: tms_reset(vec_bits[idx]);
            VEC_IR:    scan(1'b1, vec_bits[idx], vec_din[idx], got);
            VEC_DR:    scan(1'b0, vec_bits[idx], vec_din[idx], got);
            default:   ;
        endcase
        if (vec_op[idx] == VEC_CTRL) begin
            assert (ctrl == vec_dout[idx][`DBG_DATA_W-1:0]) else begin
                $display("[FAIL] %0d ns: vector %0d ctrl_o is %h, expected %h",
                         $time, idx, ctrl, vec_dout[idx][`DBG_DATA_W-1:0]);
                err_cnt++;
            end
        end else begin
            if (vec_op[idx] != VEC_RESET) begin
                assert (got == vec_dout[idx]) else begin
                    $display("[FAIL] %0d ns: vector %0d %s scan shifted out %h, expected %h",
                             $time, idx, op_name(vec_op[idx]), got, vec_dout[idx]);
                    err_cnt++;
                end
            end
            // TDO stays enabled once the first falling edge has passed
            assert (tdo_oe == 1'b1) else begin
                $display("[FAIL] %0d ns: vector %0d tdo_oe_o is low after the scan",
                         $time, idx);
                err_cnt++;
            end
        end
        if (err_cnt == errs_at_start) begin
            vec_pass++;
        end else begin
            vec_fail++;
        end
        $display("vector %0d: %s %0d bits %s", idx, op_name(vec_op[idx]), vec_bits[idx],
                 (err_cnt == errs_at_start) ? "ok" : "mismatch");
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int total_bits;
        total_bits = 0;
        load_vectors();
        foreach (vec_bits[i]) begin
            total_bits += vec_bits[i];
        end
        cycle_limit = total_bits * 8 + 2000;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        foreach (vec_op[i]) begin
            run_vector(i);
        end
        $display("Summary: %0d vectors, %0d ok, %0d mismatched, %0d check errors",
                 vec_op.size(), vec_pass, vec_fail, err_cnt);
        if (load_ok && err_cnt == 0 && vec_pass > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- logic/jtag_dbg_top.sv
// --------------------
// Debug access port top level
// TAP plus debug register bank on plain pads
// --------------------

`include "jtag_defs.svh"

module jtag_dbg_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // JTAG pads
    input  logic                   tck_i,
    input  logic                   tms_i,
    input  logic                   tdi_i,
    output logic                   tdo_o,
    output logic                   tdo_oe_o,
    // Debug register 0
    output logic [`DBG_DATA_W-1:0] ctrl_o
);

    // Strobes, instruction and return data between TAP and user register
    jtag_dr_if dr_bus ();

    jtag_tap u_tap (
        .clk      (clk),
        .rst_n    (rst_n),
        .tck_i    (tck_i),
        .tms_i    (tms_i),
        .tdi_i    (tdi_i),
        .tdo_o    (tdo_o),
        .tdo_oe_o (tdo_oe_o),
        .dr       (dr_bus.tap)
    );

    jtag_dbg_dr u_dbg_dr (
        .clk    (clk),
        .rst_n  (rst_n),
        .dr     (dr_bus.dr),
        .ctrl_o (ctrl_o)
    );

endmodule

//--- logic/jtag_dbg_dr.sv
// --------------------
// Debug user data register
// 36-bit command / status scan chain
// Four-entry register bank, entry 0 drives the control word
// --------------------

`include "jtag_defs.svh"

module jtag_dbg_dr import jtag_pkg::*; import dbg_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    jtag_dr_if.dr                  dr,
    output logic [`DBG_DATA_W-1:0] ctrl_o
);

    logic        dbg_sel;
    dbg_status_t status;
    dbg_cmd_t    cmd;
    // High in the cycle after an update, cmd is then the new command
    logic        cmd_vld_q;
    dbg_data_t   regs_q [`DBG_NREGS];
    dbg_data_t   rdata_q;
    logic        err_q;

    // Chain only reacts while its instruction is loaded
    assign dbg_sel = (dr.ir == IR_DBGREG);

    // Reply captured at the start of every scan
    assign status = '{zero: 3'b000, err: err_q, rdata: rdata_q};

    // Command stage clears back to NOP once executed
    jtag_shift_reg #(.T(dbg_cmd_t)) u_cmd_sr (
        .clk           (clk),
        .rst_n         (rst_n),
        .clr_i         (cmd_vld_q),
        .capture_i     (dr.capture && dbg_sel),
        .capture_val_i (dbg_cmd_t'(status)),
        .shift_i       (dr.shift && dbg_sel),
        .sdi_i         (dr.tdi),
        .update_i      (dr.update && dbg_sel),
        .sdo_o         (dr.tdo),
        .shift_q_o     (),
        .value_o       (cmd)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_vld_q <= 1'b0;
        end else begin
            cmd_vld_q <= dr.update && dbg_sel;
        end
    end

    // --------------------
    // Command decode
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `DBG_NREGS; i++) begin
                regs_q[i] <= '0;
            end
            rdata_q <= '0;
            err_q   <= 1'b0;
        end else if (cmd_vld_q) begin
            case (cmd.op)
                OP_WRITE: regs_q[cmd.addr] <= cmd.data;
                // Read data goes out on the next capture
                OP_READ:  rdata_q <= regs_q[cmd.addr];
                // A NOP aimed at a nonzero register is flagged, sticky
                OP_NOP: begin
                    if (cmd.addr != '0) begin
                        err_q <= 1'b1;
                    end
                end
                default:  ;
            endcase
        end
    end

    // Control word for the rest of the chip
    assign ctrl_o = regs_q[0];

endmodule

//--- logic/jtag_tap.sv
// --------------------
// JTAG TAP
// TCK oversampler, controller FSM and instruction register
// IDCODE and BYPASS data registers, TDO mux and pad register
// --------------------

`include "jtag_defs.svh"

module jtag_tap import jtag_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tck_i,
    input  logic  tms_i,
    input  logic  tdi_i,
    output logic  tdo_o,
    output logic  tdo_oe_o,
    jtag_dr_if.tap dr
);

    logic       tck_rise;
    logic       tck_fall;
    tap_state_e state;
    logic       capture_dr;
    logic       shift_dr;
    logic       update_dr;
    logic       capture_ir;
    logic       shift_ir;
    logic       update_ir;
    logic       trst_n;
    jtag_ir_t   ir;
    logic       ir_sdo;
    logic       idcode_sel;
    logic       dbg_sel;
    logic       bypass_sel;
    logic [31:0] idcode_q;
    logic       bypass_q;
    logic       tdo_mux;

    jtag_tck_sync u_tck_sync (
        .clk        (clk),
        .rst_n      (rst_n),
        .tck_i      (tck_i),
        .tck_rise_o (tck_rise),
        .tck_fall_o (tck_fall)
    );

    jtag_tap_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .tck_rise_i   (tck_rise),
        .tck_fall_i   (tck_fall),
        .tms_i        (tms_i),
        .state_o      (state),
        .capture_dr_o (capture_dr),
        .shift_dr_o   (shift_dr),
        .update_dr_o  (update_dr),
        .capture_ir_o (capture_ir),
        .shift_ir_o   (shift_ir),
        .update_ir_o  (update_ir),
        .trst_no      (trst_n)
    );

    // Instruction register, falls back to IDCODE on logic reset
    jtag_shift_reg #(.T(jtag_ir_t), .CLR_VAL(IR_IDCODE)) u_ir (
        .clk           (clk),
        .rst_n         (rst_n),
        .clr_i         (!trst_n),
        .capture_i     (capture_ir),
        .capture_val_i (IR_CAPTURE_PAT),
        .shift_i       (shift_ir),
        .sdi_i         (tdi_i),
        .update_i      (update_ir),
        .sdo_o         (ir_sdo),
        .shift_q_o     (),
        .value_o       (ir)
    );

    // --------------------
    // Data register select
    // --------------------
    assign idcode_sel = (ir == IR_IDCODE);
    assign dbg_sel    = (ir == IR_DBGREG);
    // BYPASS0, BYPASS1 and every unknown code
    assign bypass_sel = !idcode_sel && !dbg_sel;

    // IDCODE shifter and one-bit bypass
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idcode_q <= '0;
            bypass_q <= 1'b0;
        end else begin
            if (capture_dr && idcode_sel) begin
                idcode_q <= `JTAG_IDCODE;
            end else if (shift_dr && idcode_sel) begin
                idcode_q <= {tdi_i, idcode_q[31:1]};
            end
            // Bypass captures 0 so the scan shows a leading zero
            if (capture_dr && bypass_sel) begin
                bypass_q <= 1'b0;
            end else if (shift_dr && bypass_sel) begin
                bypass_q <= tdi_i;
            end
        end
    end

    // External register strobes and data
    assign dr.capture = capture_dr;
    assign dr.shift   = shift_dr;
    assign dr.update  = update_dr;
    assign dr.tdi     = tdi_i;
    assign dr.ir      = ir;

    // --------------------
    // TDO path
    // --------------------
    always_comb begin
        if (state == SHIFT_IR) begin
            tdo_mux = ir_sdo;
        end else if (idcode_sel) begin
            tdo_mux = idcode_q[0];
        end else if (dbg_sel) begin
            tdo_mux = dr.tdo;
        end else begin
            tdo_mux = bypass_q;
        end
    end

    // Pad changes on the falling edge and stays driven afterwards
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tdo_o    <= 1'b0;
            tdo_oe_o <= 1'b0;
        end else if (tck_fall) begin
            tdo_o    <= tdo_mux;
            tdo_oe_o <= 1'b1;
        end
    end

endmodule

//--- logic/jtag_shift_reg.sv
// --------------------
// Generic capture / shift / update register
// Payload type set by parameter, LSB leaves first
// --------------------

module jtag_shift_reg #(
    parameter type T       = logic [7:0],
    // Value the update stage returns to on reset or clear
    parameter T    CLR_VAL = '0
) (
    input  logic clk,
    input  logic rst_n,
    input  logic clr_i,
    input  logic capture_i,
    input  T     capture_val_i,
    input  logic shift_i,
    input  logic sdi_i,
    input  logic update_i,
    output logic sdo_o,
    output T     shift_q_o,
    output T     value_o
);

    localparam int W = $bits(T);

    logic [W-1:0] shift_q;
    T             value_q;

    // Shift stage, new bits enter at the top
    always_ff @(posedge clk) begin
        if (capture_i) begin
            shift_q <= capture_val_i;
        end else if (shift_i) begin
            shift_q <= {sdi_i, shift_q[W-1:1]};
        end
    end

    // Update stage, holds the value the rest of the chip sees
    always_ff @(posedge clk) begin
        if (!rst_n || clr_i) begin
            value_q <= CLR_VAL;
        end else if (update_i) begin
            value_q <= T'(shift_q);
        end
    end

    assign sdo_o     = shift_q[0];
    assign shift_q_o = T'(shift_q);
    assign value_o   = value_q;

endmodule

//--- logic/jtag_tap_fsm.sv
// --------------------
// TAP controller FSM
// Sixteen-state TMS walk, advances only on a TCK rising pulse
// Capture, shift, update and reset strobes
// --------------------

module jtag_tap_fsm import jtag_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tck_rise_i,
    input  logic       tck_fall_i,
    input  logic       tms_i,
    output tap_state_e state_o,
    output logic       capture_dr_o,
    output logic       shift_dr_o,
    output logic       update_dr_o,
    output logic       capture_ir_o,
    output logic       shift_ir_o,
    output logic       update_ir_o,
    output logic       trst_no
);

    tap_state_e state_q;
    tap_state_e state_d;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            TEST_LOGIC_RESET: state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_d = tms_i ? SELECT_DR        : RUN_TEST_IDLE;
            // DR column
            SELECT_DR:        state_d = tms_i ? SELECT_IR        : CAPTURE_DR;
            CAPTURE_DR:       state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
            SHIFT_DR:         state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
            EXIT1_DR:         state_d = tms_i ? UPDATE_DR        : PAUSE_DR;
            PAUSE_DR:         state_d = tms_i ? EXIT2_DR         : PAUSE_DR;
            EXIT2_DR:         state_d = tms_i ? UPDATE_DR        : SHIFT_DR;
            UPDATE_DR:        state_d = tms_i ? SELECT_DR        : RUN_TEST_IDLE;
            // IR column
            SELECT_IR:        state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
            SHIFT_IR:         state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
            EXIT1_IR:         state_d = tms_i ? UPDATE_IR        : PAUSE_IR;
            PAUSE_IR:         state_d = tms_i ? EXIT2_IR         : PAUSE_IR;
            EXIT2_IR:         state_d = tms_i ? UPDATE_IR        : SHIFT_IR;
            UPDATE_IR:        state_d = tms_i ? SELECT_DR        : RUN_TEST_IDLE;
            default:          state_d = TEST_LOGIC_RESET;
        endcase
    end

    // State moves only in the cycle of a TCK rising pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= RUN_TEST_IDLE;
        end else if (tck_rise_i) begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    // --------------------
    // Strobes
    // --------------------
    always_comb begin
        trst_no      = 1'b1;
        capture_dr_o = 1'b0;
        shift_dr_o   = 1'b0;
        update_dr_o  = 1'b0;
        capture_ir_o = 1'b0;
        shift_ir_o   = 1'b0;
        update_ir_o  = 1'b0;
        case (state_q)
            // Logic reset pulse on each rising edge spent here
            TEST_LOGIC_RESET: trst_no      = !tck_rise_i;
            CAPTURE_DR:       capture_dr_o = tck_rise_i;
            SHIFT_DR:         shift_dr_o   = tck_rise_i;
            UPDATE_DR:        update_dr_o  = tck_rise_i;
            CAPTURE_IR:       capture_ir_o = tck_rise_i;
            SHIFT_IR:         shift_ir_o   = tck_rise_i;
            // New instruction latches on the falling edge
            UPDATE_IR:        update_ir_o  = tck_fall_i;
            default:          ;
        endcase
    end

    // Never more than one strobe in flight toward the shift registers
    a_one_strobe : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({capture_dr_o, shift_dr_o, update_dr_o,
                  capture_ir_o, shift_ir_o, update_ir_o}));

endmodule

//--- logic/jtag_tck_sync.sv
// --------------------
// Test clock oversampler
// Registers the TCK pad and turns its edges into clk pulses
// --------------------

module jtag_tck_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic tck_i,
    output logic tck_rise_o,
    output logic tck_fall_o
);

    // First stage samples the pad
    logic       tck_q;
    // Two past values, bit 1 is the older one
    logic [1:0] tck_hist_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tck_q      <= 1'b0;
            tck_hist_q <= 2'b00;
        end else begin
            tck_q      <= tck_i;
            tck_hist_q <= {tck_hist_q[0], tck_q};
        end
    end

    // 01 is a rising edge, 10 a falling one
    assign tck_rise_o = (tck_hist_q == 2'b01);
    assign tck_fall_o = (tck_hist_q == 2'b10);

    // Edge pulses never overlap and TCK holds each level for two clk cycles or more
    a_edge_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        (tck_rise_o |-> !tck_fall_o) and
        ((tck_rise_o || tck_fall_o) |=> !(tck_rise_o || tck_fall_o)));

endmodule

//--- logic/jtag_dr_if.sv
// --------------------
// Link between the TAP and an external data register
// Strobes, TDI and current instruction out, TDO back
// --------------------

interface jtag_dr_if import jtag_pkg::*; ();

    // One-cycle strobes from the TAP controller
    logic     capture;
    logic     shift;
    logic     update;
    // Serial data in and current instruction, level signals
    logic     tdi;
    jtag_ir_t ir;
    // Lowest bit of the external register's shift stage
    logic     tdo;

    // TAP side
    modport tap (
        output capture, shift, update, tdi, ir,
        input  tdo
    );

    // Data register side
    modport dr (
        input  capture, shift, update, tdi, ir,
        output tdo
    );

endinterface

//--- logic/dbg_pkg.sv
// --------------------
// Debug register access types
// Operation code, address, command and status words
// --------------------

`include "jtag_defs.svh"

package dbg_pkg;

    typedef logic [`DBG_DATA_W-1:0]        dbg_data_t;
    typedef logic [$clog2(`DBG_NREGS)-1:0] dbg_addr_t;

    // Operation carried by a shifted-in command
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } dbg_op_e;

    // Command word, data sits in the low bits and leaves TDI first
    typedef struct packed {
        dbg_op_e   op;
        dbg_addr_t addr;
        dbg_data_t data;
    } dbg_cmd_t;

    // Status word captured back toward TDO
    typedef struct packed {
        logic [2:0] zero;
        logic       err;
        dbg_data_t  rdata;
    } dbg_status_t;

endpackage

//--- logic/jtag_pkg.sv
// --------------------
// TAP protocol types
// State enum, instruction word and instruction codes
// --------------------

`include "jtag_defs.svh"

package jtag_pkg;

    // Sixteen TAP controller states, standard encoding
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'd0,
        RUN_TEST_IDLE    = 4'd1,
        SELECT_DR        = 4'd2,
        CAPTURE_DR       = 4'd3,
        SHIFT_DR         = 4'd4,
        EXIT1_DR         = 4'd5,
        PAUSE_DR         = 4'd6,
        EXIT2_DR         = 4'd7,
        UPDATE_DR        = 4'd8,
        SELECT_IR        = 4'd9,
        CAPTURE_IR       = 4'd10,
        SHIFT_IR         = 4'd11,
        EXIT1_IR         = 4'd12,
        PAUSE_IR         = 4'd13,
        EXIT2_IR         = 4'd14,
        UPDATE_IR        = 4'd15
    } tap_state_e;

    // Instruction word
    typedef logic [`JTAG_IR_LEN-1:0] jtag_ir_t;

    // Instruction codes
    // Anything not listed here falls back to BYPASS
    localparam jtag_ir_t IR_BYPASS0 = jtag_ir_t'(5'h00);
    localparam jtag_ir_t IR_IDCODE  = jtag_ir_t'(5'h01);
    localparam jtag_ir_t IR_DBGREG  = jtag_ir_t'(5'h10);
    localparam jtag_ir_t IR_BYPASS1 = jtag_ir_t'(5'h1F);

    // Pattern loaded into the IR shift stage in CAPTURE_IR, low bits are 01
    localparam jtag_ir_t IR_CAPTURE_PAT = jtag_ir_t'(5'b00101);

endpackage

//--- logic/jtag_defs.svh
// --------------------
// Shared build constants for the JTAG debug port
// IR width, IDCODE value, debug register count and width
// --------------------

`ifndef JTAG_DEFS_SVH
`define JTAG_DEFS_SVH

// Instruction register width
`define JTAG_IR_LEN 5

// Identification value returned by IDCODE
// Bit 0 must stay 1 as the JTAG standard requires
`define JTAG_IDCODE 32'h1DB0_0A3F

// Debug register bank geometry
`define DBG_NREGS 4
`define DBG_DATA_W 32

`endif
